/* uart_rx_pkg.sv */
package uart_rx_pkg;

    ////////////////////////////////////////////////////////////
    // widths and rates
    ////////////////////////////////////////////////////////////

    localparam int data_w = 8;   // data bits per frame
    localparam int div_w  = 15;  // bit period counter, must hold 10416

    typedef logic [2:0] baud_sel_t;

    // clocks per bit, indexed by baud_select
    localparam logic [div_w-1:0] baud_div [0:7] = '{
        15'd10416,  // 0, slowest
        15'd2604,
        15'd652,
        15'd326,
        15'd162,
        15'd82,
        15'd54,
        15'd28      // 7, fastest
    };

    // sample points, in quarters of a bit period
    localparam int stb_shift = 2;  // divide by four
    localparam int q1_num    = 1;
    localparam int mid_num   = 2;
    localparam int q3_num    = 3;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    // one received bit as seen by the sampler
    typedef struct packed {
        logic value;  // half point sample
        logic noisy;  // quarter samples disagree with it
    } bit_s;

    // frame FSM
    typedef enum logic [3:0] {
        idle,
        start_bit,
        data_bits,
        parity_bit,
        stop_bit,
        done
    } rx_state_e;

    // one result word toward the consumer, 11 bits
    typedef struct packed {
        logic [data_w-1:0] data;
        logic              ferror;   // line moved inside a bit, or stop low
        logic              perror;   // even parity mismatch
        logic              overrun;  // results lost before this one
    } rx_result_s;

endpackage

/* rx_bit_timer.sv */
`timescale 1ns/1ps
module rx_bit_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  uart_rx_pkg::baud_sel_t baud_select,
    input  logic                  timer_restart,
    output logic                  q1_stb,
    output logic                  mid_stb,
    output logic                  q3_stb,
    output logic                  bit_end
);
    import uart_rx_pkg::*;

    logic [div_w-1:0] div_q;    // clocks per bit, latched at frame start
    logic [div_w-1:0] cnt;      // position inside the current bit
    logic             run;      // set by the first restart
    logic [div_w-1:0] q1_pt;
    logic [div_w-1:0] mid_pt;
    logic [div_w-1:0] q3_pt;
    logic [div_w-1:0] last_pt;

    ////////////////////////////////////////////////////////////
    // bit period counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_q <= baud_div[0];
            cnt   <= '0;
            run   <= 1'b0;
        end else if (timer_restart) begin
            div_q <= baud_div[baud_select];  // rate change only lands here
            cnt   <= '0;                     // count 0 on the next clock
            run   <= 1'b1;
        end else if (run) begin
            if (cnt == last_pt)
                cnt <= '0;        // bits run back to back
            else
                cnt <= cnt + 1'b1;
        end
    end

    // strobe points from the latched divisor, integer division
    assign q1_pt   = div_w'((div_q * q1_num) >> stb_shift);
    assign mid_pt  = div_w'((div_q * mid_num) >> stb_shift);
    assign q3_pt   = div_w'((div_q * q3_num) >> stb_shift);
    assign last_pt = div_q - 1'b1;

    // one clock each per bit
    assign q1_stb  = run && (cnt == q1_pt);
    assign mid_stb = run && (cnt == mid_pt);
    assign q3_stb  = run && (cnt == q3_pt);
    assign bit_end = run && (cnt == last_pt);  // last clock of the bit

endmodule

/* rx_line_sampler.sv */
`timescale 1ns/1ps
module rx_line_sampler (
    input  logic              clk,
    input  logic              reset,
    input  logic              rxd,
    input  logic              q1_stb,
    input  logic              mid_stb,
    input  logic              q3_stb,
    input  logic              bit_end,
    output logic              start_edge,
    output uart_rx_pkg::bit_s rx_bit
);

    logic [1:0] sync_q;   // 2-flop synchroniser, [1] is the clean line
    logic       line;
    logic       line_d;   // line one clock back, for edge detect
    logic       q1_s;     // quarter point sample
    logic       mid_s;    // half point sample, the bit value
    logic       q3_s;     // three quarter sample

    assign line = sync_q[1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q <= 2'b11;  // idle line is high
            line_d <= 1'b1;
        end else begin
            sync_q <= {sync_q[0], rxd};
            line_d <= line;
        end
    end

    assign start_edge = line_d & ~line;  // falling edge of synced line

    ////////////////////////////////////////////////////////////
    // three samples per bit
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q1_s  <= 1'b1;
            mid_s <= 1'b1;
            q3_s  <= 1'b1;
        end else if (q1_stb || mid_stb || q3_stb) begin
            if (q1_stb)  q1_s  <= line;
            if (mid_stb) mid_s <= line;  // start check reads this next clock
            if (q3_stb)  q3_s  <= line;
        end else if (bit_end) begin
            // re-arm at the idle level once the bit has been taken
            q1_s  <= 1'b1;
            mid_s <= 1'b1;
            q3_s  <= 1'b1;
        end
    end

    // valid while bit_end is high, all three taken by then
    assign rx_bit.value = mid_s;
    assign rx_bit.noisy = (q1_s != mid_s) || (q3_s != mid_s);

endmodule

/* rx_frame_ctrl.sv */
`timescale 1ns/1ps
module rx_frame_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rx_en,
    input  logic                    start_edge,
    input  logic                    mid_stb,
    input  logic                    bit_end,
    input  uart_rx_pkg::bit_s       rx_bit,
    output logic                    timer_restart,
    output logic                    frame_done,
    output uart_rx_pkg::rx_result_s frame
);
    import uart_rx_pkg::*;

    rx_state_e         state;
    logic [2:0]        bit_idx;   // data bit position, LSB first
    logic [data_w-1:0] data;      // shift register, payload
    logic              ferror;
    logic              perror;
    logic              mid_chk;   // clock after mid_stb in start_bit

    // restart the bit timer on the same clock the FSM leaves idle
    assign timer_restart = rx_en && (state == idle) && start_edge;
    assign frame_done    = (state == done);  // one clock, then idle

    assign frame.data    = data;
    assign frame.ferror  = ferror;
    assign frame.perror  = perror;
    assign frame.overrun = 1'b0;  // filled in by the result port

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= idle;
            bit_idx <= '0;
            ferror  <= 1'b0;
            perror  <= 1'b0;
            mid_chk <= 1'b0;
        end else if (!rx_en) begin
            state   <= idle;  // frame in progress is dropped
            mid_chk <= 1'b0;
        end else begin
            mid_chk <= mid_stb && (state == start_bit);
            case (state)
                idle: begin
                    if (start_edge) begin
                        state   <= start_bit;
                        bit_idx <= '0;
                        ferror  <= 1'b0;
                        perror  <= 1'b0;
                    end
                end
                start_bit: begin
                    if (mid_chk && rx_bit.value) begin
                        state <= idle;  // line back high at mid, false start
                    end else if (bit_end) begin
                        ferror <= ferror | rx_bit.noisy;
                        state  <= data_bits;
                    end
                end
                data_bits: begin
                    if (bit_end) begin
                        ferror  <= ferror | rx_bit.noisy;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'(data_w - 1))
                            state <= parity_bit;
                    end
                end
                parity_bit: begin
                    if (bit_end) begin
                        perror <= rx_bit.value != (^data);  // even parity
                        ferror <= ferror | rx_bit.noisy;
                        state  <= stop_bit;
                    end
                end
                stop_bit: begin
                    if (bit_end) begin
                        ferror <= ferror | rx_bit.noisy | ~rx_bit.value;  // stop low
                        state  <= done;
                    end
                end
                done:    state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // data shifts in from the top, so bit 0 ends up in data[0]
    always_ff @(posedge clk) begin
        if (rx_en && (state == data_bits) && bit_end)
            data <= {rx_bit.value, data[data_w-1:1]};
    end

endmodule

/* rx_result_port.sv */
`timescale 1ns/1ps
module rx_result_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_done,
    input  uart_rx_pkg::rx_result_s frame,
    input  logic                    result_ack,
    output logic                    result_req,
    output uart_rx_pkg::rx_result_s result
);

    // four-phase handshake
    typedef enum logic [1:0] {
        idle,          // req low, ack low, free
        req_high,      // waiting for ack
        wait_ack_low   // req dropped, waiting for ack to fall
    } port_state_e;

    port_state_e state;
    logic        ovr_mark;  // a frame was dropped since the last accept
    logic        accept;

    assign accept     = frame_done && (state == idle) && !result_ack;
    assign result_req = (state == req_high);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= idle;
            ovr_mark <= 1'b0;
        end else begin
            if (accept)
                ovr_mark <= 1'b0;          // carried by this result
            else if (frame_done)
                ovr_mark <= 1'b1;          // port busy, frame lost
            case (state)
                idle:         if (accept)      state <= req_high;
                req_high:     if (result_ack)  state <= wait_ack_low;
                wait_ack_low: if (!result_ack) state <= idle;
                default:      state <= idle;
            endcase
        end
    end

    // result held from accept until the port is idle again
    always_ff @(posedge clk) begin
        if (accept) begin
            result         <= frame;
            result.overrun <= ovr_mark;  // overrides the zero from the FSM
        end
    end

endmodule

/* uart_rx_top.sv */
`timescale 1ns/1ps
module uart_rx_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rxd,
    input  logic                    rx_en,
    input  uart_rx_pkg::baud_sel_t  baud_select,
    input  logic                    result_ack,
    output logic                    result_req,
    output uart_rx_pkg::rx_result_s result
);
    import uart_rx_pkg::*;

    logic       timer_restart;
    logic       q1_stb;
    logic       mid_stb;
    logic       q3_stb;
    logic       bit_end;
    logic       start_edge;
    bit_s       rx_bit;      // value and noise flag of the current bit
    logic       frame_done;
    rx_result_s frame;       // overrun always zero here

    ////////////////////////////////////////////////////////////
    // timing, line, frame, result
    ////////////////////////////////////////////////////////////

    rx_bit_timer u_timer (
        .clk(clk), .reset(reset), .baud_select(baud_select),
        .timer_restart(timer_restart),
        .q1_stb(q1_stb), .mid_stb(mid_stb), .q3_stb(q3_stb), .bit_end(bit_end)
    );

    rx_line_sampler u_sampler (
        .clk(clk), .reset(reset), .rxd(rxd),
        .q1_stb(q1_stb), .mid_stb(mid_stb), .q3_stb(q3_stb), .bit_end(bit_end),
        .start_edge(start_edge), .rx_bit(rx_bit)
    );

    rx_frame_ctrl u_frame (
        .clk(clk), .reset(reset), .rx_en(rx_en), .start_edge(start_edge),
        .mid_stb(mid_stb), .bit_end(bit_end), .rx_bit(rx_bit),
        .timer_restart(timer_restart), .frame_done(frame_done), .frame(frame)
    );

    rx_result_port u_port (
        .clk(clk), .reset(reset), .frame_done(frame_done), .frame(frame),
        .result_ack(result_ack), .result_req(result_req), .result(result)
    );

endmodule

/* tb_uart_rx.sv */
`timescale 1ns/1ps
module tb_uart_rx;
    import uart_rx_pkg::*;

    // one stimulus row
    typedef struct packed {
        logic [2:0] baud;
        logic [7:0] data;
        logic       rnd;       // byte taken from the LFSR instead
        logic       bad_par;
        logic       low_stop;
        logic [3:0] glitch;    // frame bit to disturb with 0 the start bit and 15 for none
        logic       en;        // rx_en during the row
        logic       runt;      // short low pulse only with no frame
        logic [1:0] nframes;   // frames sent before ack is let through
        logic       exp_fe;
        logic       exp_pe;
        logic       exp_ov;
    } row_s;

    localparam int n_rows = 12;

    logic       clk = 1'b0;
    logic       reset;
    logic       rxd;
    logic       rx_en;
    baud_sel_t  baud_select;
    logic       result_ack;
    logic       result_req;
    rx_result_s result;

    row_s        tbl [0:n_rows-1];
    rx_result_s  got_q [$];          // one entry per rising req
    logic        req_seen = 1'b0;
    logic        ack_allow = 1'b1;   // consumer holds ack off while low
    logic [31:0] lfsr;
    int          ack_delay;
    int          cycle_limit = 0;
    int          cycles;
    int          errors;
    int          checks;
    int          i;

    uart_rx_top DUT (
        .clk(clk), .reset(reset), .rxd(rxd), .rx_en(rx_en), .baud_select(baud_select),
        .result_ack(result_ack), .result_req(result_req), .result(result)
    );

    always #20 clk = ~clk;  // 40 ns period

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic int bit_clocks(input logic [2:0] sel);
        case (sel)
            3'd0: bit_clocks = 10416;
            3'd1: bit_clocks = 2604;
            3'd2: bit_clocks = 652;
            3'd3: bit_clocks = 326;
            3'd4: bit_clocks = 162;
            3'd5: bit_clocks = 82;
            3'd6: bit_clocks = 54;
            default: bit_clocks = 28;
        endcase
    endfunction

    // galois form with the taps applied when a one shifts out
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_random_byte(output logic [7:0] b);
        int k;
        for (k = 0; k < 8; k++) begin
            lfsr = lfsr_step(lfsr);  // one step per bit
            b[k] = lfsr[0];
        end
    endtask

    task automatic wait_clk();
        @(posedge clk);
        #2;  // inputs move just after the edge
    endtask

    // start, 8 data LSB first, even parity, stop, then one idle bit period
    task automatic send_frame(input logic [7:0] d, input logic bad_par,
                              input logic low_stop, input logic [3:0] glitch, input int div);
        logic [11:0] bits;
        int          b;
        int          c;
        int          q3;
        bits = {1'b1, ~low_stop, (^d) ^ bad_par, d, 1'b0};
        q3 = (3 * div) / 4;
        for (b = 0; b < 12; b++) begin
            for (c = 0; c < div; c++) begin
                // 6 clock inversion around the three quarter point
                rxd = bits[b] ^ ((b == glitch) && (c >= q3 - 3) && (c < q3 + 3));
                wait_clk();
            end
        end
    endtask

    task automatic send_runt(input int div);
        int c;
        for (c = 0; c < 12 * div; c++) begin
            rxd = (c >= div / 4);  // low for a quarter bit then high
            wait_clk();
        end
    endtask

    task automatic check_value(input int r, input string name,
                               input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error row %0d: %s = %h, expected %h", r, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_table();
        //           baud   data   rnd   bpar  lstop glitch en    runt  nf    fe    pe    ov
        tbl[0]  = '{3'd7, 8'h55, 1'b0, 1'b0, 1'b0, 4'hf, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0, 1'b0};
        tbl[1]  = '{3'd6, 8'ha3, 1'b0, 1'b0, 1'b0, 4'hf, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0, 1'b0};
        tbl[2]  = '{3'd7, 8'h00, 1'b1, 1'b0, 1'b0, 4'hf, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0, 1'b0};
        tbl[3]  = '{3'd6, 8'h00, 1'b1, 1'b0, 1'b0, 4'hf, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0, 1'b0};
        tbl[4]  = '{3'd7, 8'h3c, 1'b0, 1'b1, 1'b0, 4'hf, 1'b1, 1'b0, 2'd1, 1'b0, 1'b1, 1'b0};
        tbl[5]  = '{3'd6, 8'hc5, 1'b0, 1'b0, 1'b1, 4'hf, 1'b1, 1'b0, 2'd1, 1'b1, 1'b0, 1'b0};
        tbl[6]  = '{3'd7, 8'h96, 1'b0, 1'b0, 1'b0, 4'h4, 1'b1, 1'b0, 2'd1, 1'b1, 1'b0, 1'b0};
        tbl[7]  = '{3'd7, 8'h81, 1'b0, 1'b0, 1'b0, 4'hf, 1'b1, 1'b0, 2'd2, 1'b0, 1'b0, 1'b0};
        tbl[8]  = '{3'd6, 8'h42, 1'b0, 1'b0, 1'b0, 4'hf, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0, 1'b1};
        tbl[9]  = '{3'd7, 8'h5a, 1'b0, 1'b0, 1'b0, 4'hf, 1'b0, 1'b0, 2'd1, 1'b0, 1'b0, 1'b0};
        tbl[10] = '{3'd7, 8'h00, 1'b0, 1'b0, 1'b0, 4'hf, 1'b1, 1'b1, 2'd1, 1'b0, 1'b0, 1'b0};
        tbl[11] = '{3'd6, 8'h00, 1'b1, 1'b0, 1'b0, 4'hf, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0, 1'b0};
    endtask

    ////////////////////////////////////////////////////////////
    // one row drives a frame, waits for the handshake and compares
    ////////////////////////////////////////////////////////////

    task automatic run_row(input int r);
        row_s       row;
        rx_result_s got;
        logic [7:0] byte_v;
        logic [7:0] first;
        int         div;
        int         n;
        int         waited;
        int         err_start;
        row = tbl[r];
        err_start = errors;
        div = bit_clocks(row.baud);
        baud_select = row.baud;
        rx_en = row.en;
        byte_v = row.data;
        if (row.rnd)
            take_random_byte(byte_v);
        first = byte_v;
        ack_allow = (row.nframes < 2);  // held off so later frames overrun
        if (row.runt)
            send_runt(div);
        else begin
            for (n = 0; n < row.nframes; n++) begin
                send_frame(byte_v, row.bad_par, row.low_stop, row.glitch, div);
                byte_v = ~byte_v;  // a lost frame carries other data
            end
        end
        ack_allow = 1'b1;
        waited = 0;
        if (!row.en || row.runt) begin
            checks++;
            assert (got_q.size() == 0) else begin
                $display("row %0d: a result request came with no valid frame sent", r);
                errors++;
            end
            got_q.delete();
        end else begin
            while (got_q.size() == 0 && waited < 2 * div) begin
                wait_clk();
                waited++;
            end
            while ((result_req || result_ack) && waited < 4 * div) begin
                wait_clk();  // four-phase back to idle
                waited++;
            end
            checks++;
            assert (got_q.size() != 0) else begin
                $display("row %0d: no result request seen after the frame", r);
                errors++;
            end
            if (got_q.size() != 0) begin
                got = got_q.pop_front();
                check_value(r, "result.data", got.data, first);
                check_value(r, "result.ferror", got.ferror, row.exp_fe);
                check_value(r, "result.perror", got.perror, row.exp_pe);
                check_value(r, "result.overrun", got.overrun, row.exp_ov);
                checks++;
                assert (got_q.size() == 0 && !result_req && !result_ack) else begin
                    $display("row %0d: extra request or handshake left unfinished", r);
                    errors++;
                end
                got_q.delete();
            end
        end
        $display("row %0d: baud %0d data %h, %s", r, row.baud, first,
                 (errors == err_start) ? "ok" : "mismatch");
    endtask

    ////////////////////////////////////////////////////////////
    // consumer, monitor, timeout, main
    ////////////////////////////////////////////////////////////

    initial begin
        result_ack = 1'b0;
        ack_delay  = 0;
        forever begin
            wait_clk();
            if (result_ack && !result_req)
                result_ack = 1'b0;             // release ack once req is gone
            else if (result_req && !result_ack && ack_allow) begin
                ack_delay++;
                if (ack_delay == 3) begin      // a few clocks after req
                    result_ack = 1'b1;
                    ack_delay  = 0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (result_req && !req_seen)
            got_q.push_back(result);  // stable while req is high
        req_seen = result_req;
    end

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d clocks", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        rxd = 1'b1;  // line idles high
        rx_en = 1'b1;
        baud_select = 3'd7;
        lfsr = 32'hb9be_fbc1;
        errors = 0;
        checks = 0;
        load_table();
        cycle_limit = 200;  // reset and settle
        for (i = 0; i < n_rows; i++)
            cycle_limit += (12 * tbl[i].nframes + 5) * bit_clocks(tbl[i].baud);
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
        repeat (4) wait_clk();
        for (i = 0; i < n_rows; i++)
            run_row(i);
        $display("rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* src.f */
uart_rx_pkg.sv
rx_bit_timer.sv
rx_line_sampler.sv
rx_frame_ctrl.sv
rx_result_port.sv
uart_rx_top.sv
tb_uart_rx.sv
